//--- common/sbaskt_pkg.sv
`default_nettype none

package sbaskt_pkg;

    // SDRAM geometry
    localparam int SDRAM_AW = 22;   // Word address
    localparam int SDRAM_DW = 16;

    // Download bus
    localparam int IOCTL_AW = 25;

    // Fetch slots
    localparam int SLOT_AW = 16;    // Slot word address
    localparam int N_SLOTS = 3;
    localparam int SEL_W   = 2;     // Wide enough to index every slot

    // Byte offsets of the graphics regions in SDRAM
    localparam logic [SDRAM_AW-1:0] SCR_START = 22'h01_0000;
    localparam logic [SDRAM_AW-1:0] OBJ_START = 22'h01_4000;
    localparam logic [SDRAM_AW-1:0] PCM_START = 22'h01_c000;   // End of object graphics

    // Colour PROMs sit past everything that goes to SDRAM
    localparam logic [IOCTL_AW-1:0] PROM_START = 25'h02_0000;

    // Fractional divider ratios for the 12 MHz pixel enable
    localparam int CEN_W = 10;
    localparam logic [CEN_W-1:0] CEN_N_60 = 10'd1;     // 48 MHz / 4
    localparam logic [CEN_W-1:0] CEN_M_60 = 10'd4;
    localparam logic [CEN_W-1:0] CEN_N    = 10'd32;    // Gives 12.288 MHz
    localparam logic [CEN_W-1:0] CEN_M    = 10'd125;

    // SDRAM arbiter states
    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,   // Request raised, waiting for the controller to take it
        WAIT_RDY    // Accepted, waiting for the read word
    } fetch_state_t;

endpackage

`default_nettype wire

//--- common/rom_slot_if.sv
`default_nettype none

// Link from one slot cache to the shared SDRAM arbiter
interface rom_slot_if;

    logic                            req;    // Held until done
    logic [sbaskt_pkg::SLOT_AW-1:0]  addr;   // Slot word address
    logic [sbaskt_pkg::SDRAM_DW-1:0] data;
    logic                            done;   // Single cycle, data valid

    modport cache (
        output req,
        output addr,
        input  data,
        input  done
    );

    modport arbiter (
        input  req,
        input  addr,
        output data,
        output done
    );

endinterface

`default_nettype wire

//--- src/pixel_cen.sv
`default_nettype none

module pixel_cen (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  vsync60,     // High selects the plain 12 MHz ratio
    output logic pxl2_cen,    // ~12 MHz
    output logic pxl_cen      // ~6 MHz
);

    logic [sbaskt_pkg::CEN_W-1:0] acc;
    logic [sbaskt_pkg::CEN_W-1:0] n;
    logic [sbaskt_pkg::CEN_W-1:0] m;
    logic [sbaskt_pkg::CEN_W-1:0] sum;
    logic                         half;   // Picks every other pxl2_cen

    assign n   = vsync60 ? sbaskt_pkg::CEN_N_60 : sbaskt_pkg::CEN_N;
    assign m   = vsync60 ? sbaskt_pkg::CEN_M_60 : sbaskt_pkg::CEN_M;
    assign sum = acc + n;

    // Accumulate n per clock and take m away on each enable
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc      <= '0;
            half     <= 1'b0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
            if (sum >= m) begin
                acc      <= sum - m;
                pxl2_cen <= 1'b1;
                pxl_cen  <= half;
                half     <= ~half;
            end else begin
                acc <= sum;
            end
        end
    end

    // The slow enable must always land on a fast one
    a_cen_nested : assert property (
        @(posedge clk) disable iff (!rst_n)
        pxl_cen |-> pxl2_cen
    );

endmodule

`default_nettype wire

//--- download/rom_dwnld.sv
`default_nettype none

module rom_dwnld (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         downloading,
    input  wire  [24:0] ioctl_addr,
    input  wire  [ 7:0] ioctl_dout,
    input  wire         ioctl_wr,
    input  wire         sdram_ack,
    output logic [21:0] prog_addr,
    output logic [ 7:0] prog_data,
    output logic [ 1:0] prog_mask,   // Active low byte enables
    output logic        prog_we,
    output logic        prom_we
);

    logic [21:0] pre_addr;
    logic [21:0] swz_addr;
    logic        in_scr;
    logic        in_obj;
    logic        is_prom;
    logic        wr;

    assign pre_addr = ioctl_addr[22:1];
    assign wr       = ioctl_wr && downloading;
    assign is_prom  = ioctl_addr >= sbaskt_pkg::PROM_START;
    assign in_scr   = ioctl_addr[21:0] >= sbaskt_pkg::SCR_START &&
                      ioctl_addr[21:0] <  sbaskt_pkg::OBJ_START;
    assign in_obj   = ioctl_addr[21:0] >= sbaskt_pkg::OBJ_START &&
                      ioctl_addr[21:0] <  sbaskt_pkg::PCM_START;

    // Reorder graphics words so that one fetch holds a whole tile row
    always_comb begin
        swz_addr = pre_addr;
        if (in_scr) begin
            swz_addr[0]   = ~pre_addr[3];
            swz_addr[3:1] =  pre_addr[2:0];
        end
        if (in_obj) begin
            swz_addr[0]   = ~pre_addr[3];
            swz_addr[1]   = ~pre_addr[4];
            swz_addr[5:2] = {pre_addr[5], pre_addr[2:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            prog_data <= ioctl_dout;
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;   // Odd byte goes high
            if (is_prom) begin
                prog_addr <= ioctl_addr[21:0] - sbaskt_pkg::PROM_START[21:0];
            end else begin
                prog_addr <= swz_addr;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= wr && is_prom;
            if (wr && !is_prom) begin
                prog_we <= 1'b1;
            end else if (sdram_ack) begin
                prog_we <= 1'b0;   // SDRAM took the byte
            end
        end
    end

    a_we_excl : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(prog_we && prom_we)
    );

endmodule

`default_nettype wire

//--- rom_fetch/rom_slot_cache.sv
`default_nettype none

module rom_slot_cache #(
    parameter int DW = 16   // 8 for a byte wide client
) (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                downloading,
    input  wire                                cs,
    input  wire  [sbaskt_pkg::SLOT_AW-1:0]     addr,
    output logic [DW-1:0]                      data,
    output logic                               ok,
    rom_slot_if.cache                          fetch
);

    logic                            valid;
    logic [sbaskt_pkg::SLOT_AW-1:0]  tag;
    logic [sbaskt_pkg::SDRAM_DW-1:0] word;
    logic [sbaskt_pkg::SLOT_AW-1:0]  word_addr;
    logic [DW-1:0]                   sel_data;
    logic                            hit;
    logic                            start;

    generate
        if (DW == 8) begin : g_byte
            // Even byte of the word sits in the low half
            assign word_addr = {1'b0, addr[sbaskt_pkg::SLOT_AW-1:1]};
            assign sel_data  = addr[0] ? word[15:8] : word[7:0];
        end else begin : g_word
            assign word_addr = addr;
            assign sel_data  = word;
        end
    endgenerate

    assign hit   = valid && tag == word_addr;
    assign start = cs && !hit && !fetch.req && !downloading;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid     <= 1'b0;
            ok        <= 1'b0;
            fetch.req <= 1'b0;
        end else begin
            ok <= cs && hit && !downloading;
            if (fetch.done) begin
                valid     <= 1'b1;
                fetch.req <= 1'b0;
            end else if (start) begin
                fetch.req <= 1'b1;
            end
            if (downloading) begin
                valid <= 1'b0;   // ROM contents are being rewritten
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch.done) begin
            word <= fetch.data;
            tag  <= fetch.addr;
        end
        if (start) begin
            fetch.addr <= word_addr;
        end
        data <= sel_data;   // Lines up with ok
    end

endmodule

`default_nettype wire

//--- rom_fetch/sdram_arbiter.sv
`default_nettype none

module sdram_arbiter (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 downloading,
    rom_slot_if.arbiter                         slot0,   // Scroll
    rom_slot_if.arbiter                         slot1,   // Objects
    rom_slot_if.arbiter                         slot2,   // Main CPU
    output logic                                sdram_req,
    output logic [sbaskt_pkg::SDRAM_AW-1:0]     sdram_addr,
    input  wire                                 sdram_ack,
    input  wire                                 data_rdy,
    input  wire  [sbaskt_pkg::SDRAM_DW-1:0]     data_read
);

    sbaskt_pkg::fetch_state_t        state;
    logic [sbaskt_pkg::N_SLOTS-1:0]  req_vec;
    logic [sbaskt_pkg::N_SLOTS-1:0]  done_vec;
    logic [sbaskt_pkg::SEL_W-1:0]    pick;
    logic [sbaskt_pkg::SEL_W-1:0]    sel;    // Slot being served
    logic [sbaskt_pkg::SDRAM_AW-1:0] req_addr;
    logic                            launch;

    assign req_vec = {slot2.req, slot1.req, slot0.req};

    // Lowest index wins
    always_comb begin
        pick = sbaskt_pkg::SEL_W'(sbaskt_pkg::N_SLOTS - 1);
        for (int i = sbaskt_pkg::N_SLOTS - 1; i >= 0; i--) begin
            if (req_vec[i]) begin
                pick = sbaskt_pkg::SEL_W'(i);
            end
        end
    end

    // Word offset of each region in SDRAM
    always_comb begin
        case (pick)
            2'd0:    req_addr = (sbaskt_pkg::SCR_START >> 1) +
                                sbaskt_pkg::SDRAM_AW'(slot0.addr);
            2'd1:    req_addr = (sbaskt_pkg::OBJ_START >> 1) +
                                sbaskt_pkg::SDRAM_AW'(slot1.addr);
            default: req_addr = sbaskt_pkg::SDRAM_AW'(slot2.addr);
        endcase
    end

    assign launch = state == sbaskt_pkg::IDLE && !downloading && |req_vec;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= sbaskt_pkg::IDLE;
            sdram_req <= 1'b0;
            sel       <= '0;
        end else begin
            case (state)
                sbaskt_pkg::IDLE: begin
                    if (launch) begin
                        sel       <= pick;
                        sdram_req <= 1'b1;
                        state     <= sbaskt_pkg::WAIT_ACK;
                    end
                end
                sbaskt_pkg::WAIT_ACK: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= sbaskt_pkg::WAIT_RDY;
                    end
                end
                sbaskt_pkg::WAIT_RDY: begin
                    if (data_rdy) state <= sbaskt_pkg::IDLE;
                end
                default: state <= sbaskt_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (launch) sdram_addr <= req_addr;
    end

    // Read word goes straight back to the waiting slot
    assign done_vec = (state == sbaskt_pkg::WAIT_RDY && data_rdy) ?
                      sbaskt_pkg::N_SLOTS'(1) << sel : '0;

    assign slot0.done = done_vec[0];
    assign slot1.done = done_vec[1];
    assign slot2.done = done_vec[2];
    assign slot0.data = data_read;
    assign slot1.data = data_read;
    assign slot2.data = data_read;

    a_req_until_ack : assert property (
        @(posedge clk) disable iff (!rst_n)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr)
    );

    // Each answer reaches one slot and that slot is still asking
    a_done_single : assert property (
        @(posedge clk) disable iff (!rst_n)
        |done_vec |-> $onehot(done_vec) && |(done_vec & req_vec)
    );

endmodule

`default_nettype wire

//--- src/sbaskt_rom_sub.sv
`default_nettype none

module sbaskt_rom_sub (
    input  wire         clk,
    input  wire         rst_n,
    // Pixel enables
    input  wire         vsync60,
    output logic        pxl2_cen,
    output logic        pxl_cen,
    // ROM download
    input  wire         downloading,
    input  wire  [24:0] ioctl_addr,
    input  wire  [ 7:0] ioctl_dout,
    input  wire         ioctl_wr,
    output logic [21:0] prog_addr,
    output logic [ 7:0] prog_data,
    output logic [ 1:0] prog_mask,
    output logic        prog_we,
    output logic        prom_we,
    // Main CPU ROM, byte address
    input  wire         main_cs,
    input  wire  [15:0] main_addr,
    output logic [ 7:0] main_data,
    output logic        main_ok,
    // Scroll graphics
    input  wire         scr_cs,
    input  wire  [15:0] scr_addr,
    output logic [15:0] scr_data,
    output logic        scr_ok,
    // Object graphics
    input  wire         obj_cs,
    input  wire  [15:0] obj_addr,
    output logic [15:0] obj_data,
    output logic        obj_ok,
    // SDRAM
    output logic        sdram_req,
    output logic [21:0] sdram_addr,
    input  wire         sdram_ack,
    input  wire         data_rdy,
    input  wire  [15:0] data_read
);

    rom_slot_if scr_fetch ();
    rom_slot_if obj_fetch ();
    rom_slot_if main_fetch ();

    pixel_cen u_cen (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .vsync60  ( vsync60  ),
        .pxl2_cen ( pxl2_cen ),
        .pxl_cen  ( pxl_cen  )
    );

    rom_dwnld u_dwnld (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .prom_we     ( prom_we     )
    );

    rom_slot_cache #(.DW(16)) u_scr_cache (
        .clk ( clk ), .rst_n ( rst_n ), .downloading ( downloading ),
        .cs  ( scr_cs   ), .addr ( scr_addr ), .data ( scr_data ), .ok ( scr_ok ),
        .fetch ( scr_fetch )
    );

    rom_slot_cache #(.DW(16)) u_obj_cache (
        .clk ( clk ), .rst_n ( rst_n ), .downloading ( downloading ),
        .cs  ( obj_cs   ), .addr ( obj_addr ), .data ( obj_data ), .ok ( obj_ok ),
        .fetch ( obj_fetch )
    );

    rom_slot_cache #(.DW(8)) u_main_cache (
        .clk ( clk ), .rst_n ( rst_n ), .downloading ( downloading ),
        .cs  ( main_cs  ), .addr ( main_addr ), .data ( main_data ), .ok ( main_ok ),
        .fetch ( main_fetch )
    );

    // Graphics slots get served ahead of the CPU
    sdram_arbiter u_arbiter (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .slot0       ( scr_fetch   ),
        .slot1       ( obj_fetch   ),
        .slot2       ( main_fetch  ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( sdram_addr  ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   )
    );

endmodule

`default_nettype wire

//--- testbench/sdram_model.sv
`default_nettype none

module sdram_model (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         sdram_req,
    input  wire  [21:0] sdram_addr,
    input  wire         prog_we,      // Download writes share the ack
    output logic        sdram_ack,
    output logic        data_rdy,
    output logic [15:0] data_read
);

    timeunit 1ns;
    timeprecision 100ps;

    integer      seed = 32'h62d4_1784;
    logic        busy;
    logic        is_read;
    logic [21:0] addr_q;
    logic [ 2:0] delay;    // Cycles from ack to data

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            is_read   <= 1'b0;
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            data_read <= '0;
            addr_q    <= '0;
            delay     <= '0;
        end else begin
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            if (!busy) begin
                if (sdram_req || prog_we) begin
                    busy      <= 1'b1;
                    sdram_ack <= 1'b1;
                    is_read   <= sdram_req;
                    addr_q    <= sdram_addr;
                    delay     <= 3'(2 + $unsigned($random(seed)) % 5);
                end
            end else if (sdram_ack) begin
                if (!is_read) busy <= 1'b0;   // Writes end with the ack
            end else if (delay > 3'd1) begin
                delay <= delay - 3'd1;
            end else begin
                data_rdy  <= 1'b1;
                data_read <= addr_q[15:0] ^ 16'h5a5a;
                busy      <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_sbaskt.sv
`default_nettype none

module tb_sbaskt;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_HALF = 4;     // 8 ns clock
    localparam int MAX_REC  = 64;
    localparam int REC_CYC  = 200;   // Watchdog budget per data file line
    localparam int WAIT_MAX = 100;

    logic        clk;
    logic        rst_n;
    logic        vsync60;
    logic        pxl2_cen;
    logic        pxl_cen;
    logic        downloading;
    logic [24:0] ioctl_addr;
    logic [ 7:0] ioctl_dout;
    logic        ioctl_wr;
    logic [21:0] prog_addr;
    logic [ 7:0] prog_data;
    logic [ 1:0] prog_mask;
    logic        prog_we;
    logic        prom_we;
    logic [ 7:0] main_data;
    logic [15:0] scr_data;
    logic [15:0] obj_data;
    logic        sdram_req;
    logic [21:0] sdram_addr;
    logic        sdram_ack;
    logic        data_rdy;
    logic [15:0] data_read;

    // Slot 0 is scroll, 1 objects, 2 main CPU
    logic [ 2:0] cs_v;
    logic [15:0] addr_v [3];
    logic [ 2:0] ok_v;
    logic [15:0] data_v [3];

    logic [75:0] stim [MAX_REC];   // Op, address, argument, expected
    logic [ 2:0] pend;             // Fetches started without waiting
    logic [15:0] pend_exp [3];
    int          n_rec;
    logic        stim_ready;

    assign data_v[0] = scr_data;
    assign data_v[1] = obj_data;
    assign data_v[2] = {8'h00, main_data};

    sbaskt_rom_sub sbaskt_rom_sub_inst (
        .clk ( clk ), .rst_n ( rst_n ), .vsync60 ( vsync60 ),
        .pxl2_cen ( pxl2_cen ), .pxl_cen ( pxl_cen ), .downloading ( downloading ),
        .ioctl_addr ( ioctl_addr ), .ioctl_dout ( ioctl_dout ), .ioctl_wr ( ioctl_wr ),
        .prog_addr ( prog_addr ), .prog_data ( prog_data ), .prog_mask ( prog_mask ),
        .prog_we ( prog_we ), .prom_we ( prom_we ),
        .main_cs ( cs_v[2] ), .main_addr ( addr_v[2] ), .main_data ( main_data ),
        .main_ok ( ok_v[2] ),
        .scr_cs ( cs_v[0] ), .scr_addr ( addr_v[0] ), .scr_data ( scr_data ),
        .scr_ok ( ok_v[0] ),
        .obj_cs ( cs_v[1] ), .obj_addr ( addr_v[1] ), .obj_data ( obj_data ),
        .obj_ok ( ok_v[1] ),
        .sdram_req ( sdram_req ), .sdram_addr ( sdram_addr ), .sdram_ack ( sdram_ack ),
        .data_rdy ( data_rdy ), .data_read ( data_read )
    );

    sdram_model u_sdram (
        .clk ( clk ), .rst_n ( rst_n ), .sdram_req ( sdram_req ),
        .sdram_addr ( sdram_addr ), .prog_we ( prog_we ), .sdram_ack ( sdram_ack ),
        .data_rdy ( data_rdy ), .data_read ( data_read )
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("ERROR %0t: %s", $time, msg));
    endtask

    task automatic write_byte(input logic [24:0] a, input logic [7:0] d,
                              input logic [31:0] exp);
        int n;
        @(negedge clk);
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
        assert (prog_we && !prom_we)
            else report_mismatch($sformatf("byte at %h did not raise prog_we alone", a));
        assert (prog_addr == exp[21:0] && prog_mask == exp[25:24] && prog_data == d)
            else report_mismatch($sformatf("byte at %h gave addr %h mask %b data %h",
                                           a, prog_addr, prog_mask, prog_data));
        n = 0;
        while (prog_we && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        assert (!prog_we) else abort_run("prog_we was never cleared by the SDRAM ack");
    endtask

    task automatic write_prom(input logic [24:0] a, input logic [7:0] d);
        @(negedge clk);
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
        assert (prom_we && !prog_we && prog_data == d)
            else report_mismatch($sformatf("PROM byte at %h gave prom_we %b prog_we %b",
                                           a, prom_we, prog_we));
        @(negedge clk);
        assert (!prom_we && !prog_we)
            else report_mismatch($sformatf("prom_we held past one cycle at %h", a));
    endtask

    task automatic fetch_slot(input int s, input logic [15:0] a, input logic [7:0] flags,
                              input logic [15:0] exp);
        int n;
        @(negedge clk);
        cs_v[s]   = 1'b1;
        addr_v[s] = a;
        if (flags[1]) begin
            pend[s]     = 1'b1;   // Result checked by wait_pending
            pend_exp[s] = exp;
        end else begin
            n = 0;
            @(negedge clk);
            while (!ok_v[s] && n < WAIT_MAX) begin
                @(negedge clk);
                n++;
            end
            assert (ok_v[s]) else abort_run($sformatf("slot %0d gave no ok for %h", s, a));
            assert (data_v[s] == exp)
                else report_mismatch($sformatf("slot %0d address %h read %h, expected %h",
                                               s, a, data_v[s], exp));
            if (flags[0]) begin
                // Cached word answers at once and never reaches the SDRAM
                assert (n == 0 && !sdram_req)
                    else report_mismatch($sformatf("slot %0d address %h missed", s, a));
                @(negedge clk);
                assert (!sdram_req)
                    else report_mismatch($sformatf("slot %0d hit raised sdram_req", s));
            end
            cs_v[s] = 1'b0;
        end
    endtask

    task automatic wait_pending();
        int n;
        n = 0;
        while (pend != 3'b000 && n < 2 * WAIT_MAX) begin
            @(negedge clk);
            n++;
            for (int s = 0; s < 3; s++) begin
                if (pend[s] && ok_v[s]) begin
                    assert (data_v[s] == pend_exp[s])
                        else report_mismatch($sformatf("slot %0d read %h, expected %h",
                                                       s, data_v[s], pend_exp[s]));
                    pend[s] = 1'b0;
                    cs_v[s] = 1'b0;
                end
            end
        end
        assert (pend == 3'b000) else abort_run("some slots never finished their fetch");
    endtask

    task automatic idle_no_req(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (!sdram_req) else report_mismatch("sdram_req raised while downloading");
        end
    endtask

    task automatic count_cen(input logic vs, input int cycles, input logic [31:0] exp);
        int n2;
        int n1;
        int d2;
        int d1;
        @(negedge clk);
        vsync60 = vs;
        repeat (200) @(negedge clk);   // Accumulator settles after a ratio change
        n2 = 0;
        n1 = 0;
        repeat (cycles) begin
            @(negedge clk);
            if (pxl2_cen) n2++;
            if (pxl_cen) n1++;
        end
        d2 = n2 - int'(exp[15:0]);
        d1 = n1 - int'(exp[31:16]);
        assert (d2 >= -1 && d2 <= 1 && d1 >= -1 && d1 <= 1)
            else report_mismatch($sformatf("vsync60 %b gave %0d pxl2_cen and %0d pxl_cen",
                                           vs, n2, n1));
    endtask

    task automatic execute_record(input logic [75:0] rec, input int idx);
        logic [ 3:0] op;
        logic [31:0] a;
        logic [ 7:0] arg;
        logic [31:0] exp;
        op  = rec[75:72];
        a   = rec[71:40];
        arg = rec[39:32];
        exp = rec[31:0];
        case (op)
            4'h1: write_byte(a[24:0], arg, exp);
            4'h2: write_prom(a[24:0], arg);
            4'h3, 4'h4, 4'h5: fetch_slot(int'(op) - 3, a[15:0], arg, exp[15:0]);
            4'h7: wait_pending();
            4'h8: begin
                @(negedge clk);
                downloading = arg[0];
            end
            4'h9: idle_no_req(int'(a));
            4'ha: count_cen(arg[0], int'(a), exp);
            default: abort_run($sformatf("unknown opcode %h in data record %0d", op, idx));
        endcase
    endtask

    // Watchdog
    initial begin
        wait (stim_ready);
        repeat ((n_rec + 1) * REC_CYC) @(posedge clk);
        abort_run($sformatf("Timeout: run did not end within %0d clock cycles",
                            (n_rec + 1) * REC_CYC));
    end

    initial begin
        rst_n       = 1'b0;
        vsync60     = 1'b1;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        cs_v        = '0;
        pend        = '0;
        n_rec       = 0;
        stim_ready  = 1'b0;
        for (int s = 0; s < 3; s++) begin
            addr_v[s]   = '0;
            pend_exp[s] = '0;
        end
        $readmemh("testbench/sbaskt_input.txt", stim);
        while (n_rec < MAX_REC && stim[n_rec][75:72] != 4'hf) n_rec++;
        assert (n_rec < MAX_REC) else abort_run("data file has no end record");
        stim_ready = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < n_rec; i++) execute_record(stim[i], i);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/sbaskt_input.txt
// Columns: op_address_argument_expected, all hex. Ops: 1 byte, 2 PROM byte, 3/4/5 scr/obj/main
// fetch (arg 1 hit, 2 no wait), 7 wait, 8 downloading=arg, 9 idle, a cen count (arg vsync60), f end
8_00000000_01_00000000
1_00000123_5a_01000091
1_0000abcc_c3_020055e6
1_0001000a_11_0200800b
1_00013fff_22_01009ffe
1_00014024_33_0200a009
1_0001bfff_44_0100dffc
1_0001c010_55_0200e008
2_00020003_66_00000000
2_0002001f_77_00000000
8_00000000_00_00000000
3_00000010_00_0000da4a
4_00000123_00_0000fb79
5_00001235_00_00000053
3_00000010_01_0000da4a
4_00000123_01_0000fb79
5_00001235_01_00000053
5_00001234_01_00000040
3_00000200_02_0000d85a
4_00000040_02_0000fa1a
5_00004001_02_0000007a
7_00000000_00_00000000
8_00000000_01_00000000
3_00000777_02_0000dd2d
9_00000014_00_00000000
8_00000000_00_00000000
7_00000000_00_00000000
a_000003e8_01_007d00fa
a_000003e8_00_00800100
f_00000000_00_00000000

//--- sbaskt_rom.f
common/sbaskt_pkg.sv
common/rom_slot_if.sv
src/pixel_cen.sv
download/rom_dwnld.sv
rom_fetch/rom_slot_cache.sv
rom_fetch/sdram_arbiter.sv
src/sbaskt_rom_sub.sv
testbench/sdram_model.sv
testbench/tb_sbaskt.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sbaskt_rom.f --top-module tb_sbaskt -o sim_tb
out=$(./obj_dir/sim_tb 2>&1) || true
echo "$out"
echo "$out" | grep -qx "Testbench passed"
